/* design/frontend_macros.svh */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Front end sizing and reset values
//////////////////////////////////////////////////////////////////////

// First fetch address after reset
`define FE_RESET_PC 32'h0000_1000

// Fetch buffer entries, must be a power of two
`define FE_BUF_DEPTH 8

// Number of 2-bit counters in the branch history table
// Indexed by pc bits starting at bit 2
`define FE_BHT_ENTRIES 64

`endif

/* design/frontend_pkg.sv */
package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction cache interface
    //////////////////////////////////////////////////////////////////////

    // Request from pc_gen to the cache
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    // Cache response, one cycle after an accepted request
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_resp_t;

    //////////////////////////////////////////////////////////////////////
    // Control flow
    //////////////////////////////////////////////////////////////////////

    // Next-PC override, used for both prediction and back-end flush
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // Resolved branch outcome from the back end
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        is_cond_branch;
        logic        taken;
    } bpu_update_t;

    //////////////////////////////////////////////////////////////////////
    // Fetch buffer payload
    //////////////////////////////////////////////////////////////////////

    // One predicted instruction on its way to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        // Prediction made at fetch time
        logic        pred_taken;
        // Target if taken, else the next sequential pc
        logic [31:0] pred_target;
    } fetch_entry_t;

endpackage

/* design/pc_gen.sv */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module pc_gen (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     icache_stall,
    input  logic                     fetch_hold,
    input  frontend_pkg::redirect_t  flush,
    input  frontend_pkg::redirect_t  predict,
    output frontend_pkg::fetch_req_t fetch_req
);

    // Current fetch address
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] pc_seq;

    // Set one clock after reset releases
    logic running;

    logic req_valid;
    logic req_accept;

    //////////////////////////////////////////////////////////////////////
    // Request generation
    //////////////////////////////////////////////////////////////////////

    // No request while the buffer is close to full
    assign req_valid  = running && !fetch_hold;
    assign req_accept = req_valid && !icache_stall;

    assign pc_seq = pc + 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Next PC selection
    //////////////////////////////////////////////////////////////////////

    // Flush beats prediction, both override a held pc
    always_comb begin
        if (flush.valid) begin
            pc_next = flush.target;
        end else if (predict.valid) begin
            pc_next = predict.target;
        end else if (req_accept) begin
            pc_next = pc_seq;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= `FE_RESET_PC;
        end else begin
            running <= 1'b1;
            pc      <= pc_next;
        end
    end

    // Request to the cache
    assign fetch_req.valid = req_valid;
    assign fetch_req.pc    = pc;

endmodule

/* design/branch_predictor.sv */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module branch_predictor (
    input  logic                       clk,
    input  logic                       reset,
    input  frontend_pkg::fetch_resp_t  fetch_resp,
    input  frontend_pkg::redirect_t    flush,
    input  frontend_pkg::bpu_update_t  bpu_update,
    output frontend_pkg::redirect_t    predict,
    output logic                       entry_valid,
    output frontend_pkg::fetch_entry_t entry
);

    localparam int         IDX_W      = $clog2(`FE_BHT_ENTRIES);
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Branch history table of 2-bit saturating counters
    logic [1:0] bht [`FE_BHT_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // Drops the one response still in flight after a redirect
    logic squash;
    logic resp_live;

    logic [6:0]  opcode;
    logic        is_jal;
    logic        is_branch;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic [31:0] target;
    logic [31:0] pc_seq;
    logic        pred_hit;

    //////////////////////////////////////////////////////////////////////
    // Decode of the returned instruction
    //////////////////////////////////////////////////////////////////////

    assign opcode    = fetch_resp.inst[6:0];
    assign is_jal    = (opcode == OPC_JAL);
    assign is_branch = (opcode == OPC_BRANCH);

    // J-type and B-type immediates, sign extended
    assign imm_j = {{11{fetch_resp.inst[31]}}, fetch_resp.inst[31],
                    fetch_resp.inst[19:12], fetch_resp.inst[20],
                    fetch_resp.inst[30:21], 1'b0};
    assign imm_b = {{19{fetch_resp.inst[31]}}, fetch_resp.inst[31],
                    fetch_resp.inst[7], fetch_resp.inst[30:25],
                    fetch_resp.inst[11:8], 1'b0};

    assign target = is_jal ? fetch_resp.pc + imm_j : fetch_resp.pc + imm_b;
    assign pc_seq = fetch_resp.pc + 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////////////////////////

    assign rd_idx = fetch_resp.pc[IDX_W+1:2];

    // JAL always taken, branches follow the counter's upper bit
    assign pred_hit = is_jal || (is_branch && bht[rd_idx][1]);

    // A flush in this cycle kills the current response as well
    assign resp_live = fetch_resp.valid && !squash && !flush.valid;

    assign predict.valid  = resp_live && pred_hit;
    assign predict.target = target;

    assign entry_valid       = resp_live;
    assign entry.pc          = fetch_resp.pc;
    assign entry.inst        = fetch_resp.inst;
    assign entry.pred_taken  = pred_hit;
    assign entry.pred_target = pred_hit ? target : pc_seq;

    // Only the response in the next cycle can be on the wrong path
    always_ff @(posedge clk) begin
        if (reset) begin
            squash <= 1'b0;
        end else begin
            squash <= flush.valid || predict.valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter training
    //////////////////////////////////////////////////////////////////////

    assign wr_idx = bpu_update.pc[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Weakly not taken
            for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (bpu_update.valid && bpu_update.is_cond_branch) begin
            if (bpu_update.taken && bht[wr_idx] != 2'b11) begin
                bht[wr_idx] <= bht[wr_idx] + 2'd1;
            end else if (!bpu_update.taken && bht[wr_idx] != 2'b00) begin
                bht[wr_idx] <= bht[wr_idx] - 2'd1;
            end
        end
    end

endmodule

/* design/fetch_buffer.sv */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module fetch_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  frontend_pkg::redirect_t    flush,
    input  logic                       entry_valid,
    input  frontend_pkg::fetch_entry_t entry,
    output logic                       fetch_hold,
    output logic                       inst_valid,
    output frontend_pkg::fetch_entry_t inst_out,
    input  logic                       inst_ready
);

    localparam int PTR_W = $clog2(`FE_BUF_DEPTH);

    localparam logic [PTR_W:0] DEPTH_C    = `FE_BUF_DEPTH;
    // Leaves room for the one response still in flight
    localparam logic [PTR_W:0] HOLD_LEVEL = `FE_BUF_DEPTH - 2;

    // Entry storage
    frontend_pkg::fetch_entry_t mem [`FE_BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic full;
    logic push;
    logic pop;

    //////////////////////////////////////////////////////////////////////
    // Status and handshake
    //////////////////////////////////////////////////////////////////////

    assign full       = (count == DEPTH_C);
    assign inst_valid = (count != '0);
    assign fetch_hold = (count >= HOLD_LEVEL);

    // Oldest entry, stable until it is taken
    assign inst_out = mem[rd_ptr];

    assign push = entry_valid && !full && !flush.valid;
    assign pop  = inst_valid && inst_ready && !flush.valid;

    //////////////////////////////////////////////////////////////////////
    // Storage write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    // A flush drops everything queued
    always_ff @(posedge clk) begin
        if (reset || flush.valid) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Both or neither, occupancy unchanged
                    count <= count;
                end
            endcase
        end
    end

endmodule

/* design/frontend_top.sv */
`timescale 1ns/100ps

module frontend_top (
    input  logic                       clk,
    input  logic                       reset,

    // Instruction cache
    output frontend_pkg::fetch_req_t   fetch_req,
    input  logic                       icache_stall,
    input  frontend_pkg::fetch_resp_t  fetch_resp,

    // Back end control
    input  frontend_pkg::redirect_t    flush,
    input  frontend_pkg::bpu_update_t  bpu_update,

    // Back end instruction stream
    output logic                       inst_valid,
    output frontend_pkg::fetch_entry_t inst_out,
    input  logic                       inst_ready
);

    // Between the stages
    frontend_pkg::redirect_t    predict;
    frontend_pkg::fetch_entry_t entry;
    logic                       entry_valid;
    logic                       fetch_hold;

    pc_gen i_pc_gen (
        .clk,
        .reset,
        .icache_stall,
        .fetch_hold,
        .flush,
        .predict,
        .fetch_req
    );

    branch_predictor i_branch_predictor (
        .clk,
        .reset,
        .fetch_resp,
        .flush,
        .bpu_update,
        .predict,
        .entry_valid,
        .entry
    );

    fetch_buffer i_fetch_buffer (
        .clk,
        .reset,
        .flush,
        .entry_valid,
        .entry,
        .fetch_hold,
        .inst_valid,
        .inst_out,
        .inst_ready
    );

endmodule

/* testbench/frontend_chk.sv */
`timescale 1ns/100ps

module frontend_chk (
    input logic                       clk,
    input logic                       reset,
    input frontend_pkg::fetch_req_t   fetch_req,
    input logic                       fetch_hold,
    input frontend_pkg::redirect_t    flush,
    input logic                       inst_valid,
    input logic                       inst_ready,
    input frontend_pkg::fetch_entry_t inst_out
);

    // Back end sees a frozen entry until it takes it
    a_inst_stable: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_ready && !flush.valid |=> inst_valid && $stable(inst_out))
        else $error("inst_out changed while inst_ready was low");

    a_hold_no_req: assert property (@(posedge clk) disable iff (reset)
        fetch_hold |-> !fetch_req.valid)
        else $error("fetch request issued under fetch_hold");

    // Nothing leaves the front end while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !fetch_req.valid && !inst_valid)
        else $error("request or instruction valid during reset");

endmodule

bind frontend_top frontend_chk i_frontend_chk (
    .clk,
    .reset,
    .fetch_req,
    .fetch_hold,
    .flush,
    .inst_valid,
    .inst_ready,
    .inst_out
);

/* testbench/frontend_tb.sv */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module frontend_tb;

    localparam int PROG_WORDS = 64;
    localparam int NUM_ROWS   = 9;
    localparam int BHT_W      = $clog2(`FE_BHT_ENTRIES);

    localparam logic [1:0] ACT_NONE  = 2'd0;
    localparam logic [1:0] ACT_FLUSH = 2'd1;
    localparam logic [1:0] ACT_TRAIN = 2'd2;

    // Action and its address, trained outcome, ready mode, deliveries to check, last pc
    typedef struct packed {
        logic [1:0]  act;
        logic [31:0] addr;
        logic        taken;
        logic        rnd;
        int          count;
        logic [31:0] end_pc;
    } row_t;

    logic clk;
    logic reset;
    logic icache_stall;
    logic inst_ready;
    logic inst_valid;
    frontend_pkg::fetch_req_t   fetch_req;
    frontend_pkg::fetch_resp_t  fetch_resp;
    frontend_pkg::redirect_t    flush;
    frontend_pkg::bpu_update_t  bpu_update;
    frontend_pkg::fetch_entry_t inst_out;

    // Program image and the control flow of each word
    logic [31:0] prog [PROG_WORDS];
    logic        is_jal_at [PROG_WORDS];
    logic        is_br_at [PROG_WORDS];
    logic [31:0] tgt_at [PROG_WORDS];

    // Expected state of the predictor counters
    logic [1:0]  model_bht [`FE_BHT_ENTRIES];

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;
    logic        pend_valid;
    logic [31:0] pend_pc;
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    // Request expected at the next falling edge
    logic        req_check;
    logic [31:0] req_exp_pc;
    int          errors;
    int          checked;
    int          cycles;
    int          limit;

    frontend_top i_dut (
        .clk,
        .reset,
        .fetch_req,
        .icache_stall,
        .fetch_resp,
        .flush,
        .bpu_update,
        .inst_valid,
        .inst_out,
        .inst_ready
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program and memory model
    //////////////////////////////////////////////////////////////////////

    // Non-branch OP-IMM word whose upper bits follow the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] pc);
        return ((pc ^ (pc << 13)) & 32'hFFFF_FF80) | 32'h0000_0013;
    endfunction

    function automatic logic in_prog(input logic [31:0] pc);
        return (pc >= `FE_RESET_PC) && (pc < `FE_RESET_PC + 4 * PROG_WORDS);
    endfunction

    function automatic logic [5:0] word_of(input logic [31:0] pc);
        logic [31:0] off;
        off = pc - `FE_RESET_PC;
        return off[7:2];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] pc);
        return in_prog(pc) ? prog[word_of(pc)] : fill_word(pc);
    endfunction

    function automatic row_t make_row(input logic [1:0] act, input logic [31:0] addr,
                                      input logic taken, input logic rnd, input int count,
                                      input logic [31:0] end_pc);
        row_t r;
        r.act    = act;
        r.addr   = addr;
        r.taken  = taken;
        r.rnd    = rnd;
        r.count  = count;
        r.end_pc = end_pc;
        return r;
    endfunction

    // jal x0, off
    task automatic place_jal(input logic [5:0] w, input logic [31:0] off);
        prog[w]      = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
        is_jal_at[w] = 1'b1;
        tgt_at[w]    = `FE_RESET_PC + {24'd0, w, 2'b00} + off;
    endtask

    // beq x0, x0, off
    task automatic place_beq(input logic [5:0] w, input logic [31:0] off);
        prog[w]     = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
        is_br_at[w] = 1'b1;
        tgt_at[w]   = `FE_RESET_PC + {24'd0, w, 2'b00} + off;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i]      = fill_word(`FE_RESET_PC + 32'(4 * i));
            is_jal_at[i] = 1'b0;
            is_br_at[i]  = 1'b0;
            tgt_at[i]    = '0;
        end
        for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
            model_bht[i] = 2'b01;
        end
        // JAL at 0x1010 to 0x1030 and a loop branch at 0x1040 back to 0x1030
        place_jal(6'd4, 32'd32);
        place_beq(6'd16, 32'hFFFF_FFF0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////////////////////////

    task automatic next_bit(output logic b);
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        b    = lfsr[0];
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_entry(input frontend_pkg::fetch_entry_t e);
        logic             exp_taken;
        logic [31:0]      exp_tgt;
        logic [5:0]       w;
        logic [BHT_W-1:0] idx;
        w         = word_of(exp_pc);
        idx       = exp_pc[BHT_W+1:2];
        exp_taken = 1'b0;
        exp_tgt   = exp_pc + 32'd4;
        if (in_prog(exp_pc) && is_jal_at[w]) begin
            exp_taken = 1'b1;
        end
        if (in_prog(exp_pc) && is_br_at[w]) begin
            exp_taken = model_bht[idx][1];
        end
        if (exp_taken) begin
            exp_tgt = tgt_at[w];
        end
        checked++;
        last_pc = e.pc;
        if (e.pc != exp_pc) begin
            report_mismatch($sformatf("pc %h, expected %h", e.pc, exp_pc));
        end
        if (e.inst != mem_word(exp_pc)) begin
            report_mismatch($sformatf("inst %h at %h, expected %h", e.inst, exp_pc,
                                      mem_word(exp_pc)));
        end
        if (e.pred_taken != exp_taken) begin
            report_mismatch($sformatf("pred_taken %b at %h", e.pred_taken, exp_pc));
        end
        if (e.pred_target != exp_tgt) begin
            report_mismatch($sformatf("pred_target %h at %h, expected %h",
                                      e.pred_target, exp_pc, exp_tgt));
        end
        exp_pc = exp_tgt;
    endtask

    // One clock of cache model and back end driven on the falling edge
    task automatic run_cycle(input logic rnd, input logic take);
        logic b0;
        logic b1;
        @(negedge clk);
        if (req_check) begin
            if (!fetch_req.valid || fetch_req.pc != req_exp_pc) begin
                report_mismatch($sformatf("request valid %b pc %h, expected pc %h",
                                          fetch_req.valid, fetch_req.pc, req_exp_pc));
            end
            req_check = 1'b0;
        end
        flush      = '0;
        bpu_update = '0;
        fetch_resp.valid = pend_valid;
        fetch_resp.pc    = pend_pc;
        fetch_resp.inst  = mem_word(pend_pc);
        b0 = 1'b0;
        b1 = 1'b0;
        if (rnd) begin
            next_bit(b0);
            next_bit(b1);
        end
        icache_stall = b0 && b1;
        pend_valid   = fetch_req.valid && !icache_stall;
        pend_pc      = fetch_req.pc;
        b0 = take;
        if (take && rnd) begin
            next_bit(b0);
        end
        inst_ready = b0;
        // Transfer happens on the coming rising edge
        if (inst_valid && inst_ready) begin
            check_entry(inst_out);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [BHT_W-1:0] idx;
        int               start;
        idx = r.addr[BHT_W+1:2];
        if (r.act != ACT_NONE) begin
            run_cycle(1'b0, 1'b0);
            if (r.act == ACT_FLUSH) begin
                flush.valid  = 1'b1;
                flush.target = r.addr;
                exp_pc       = r.addr;
                req_check    = 1'b1;
                req_exp_pc   = r.addr;
            end else begin
                bpu_update.valid          = 1'b1;
                bpu_update.pc             = r.addr;
                bpu_update.is_cond_branch = 1'b1;
                bpu_update.taken          = r.taken;
                if (r.taken && model_bht[idx] != 2'b11) begin
                    model_bht[idx] = model_bht[idx] + 2'd1;
                end else if (!r.taken && model_bht[idx] != 2'b00) begin
                    model_bht[idx] = model_bht[idx] - 2'd1;
                end
            end
        end
        start = checked;
        while (checked - start < r.count) begin
            run_cycle(r.rnd, 1'b1);
        end
        if (r.count > 0 && last_pc != r.end_pc) begin
            report_mismatch($sformatf("row ended at pc %h, expected %h", last_pc, r.end_pc));
        end
    endtask

    initial begin
        reset        = 1'b1;
        icache_stall = 1'b0;
        inst_ready   = 1'b0;
        fetch_resp   = '0;
        flush        = '0;
        bpu_update   = '0;
        lfsr         = 16'd42;
        pend_valid   = 1'b0;
        pend_pc      = '0;
        exp_pc       = `FE_RESET_PC;
        last_pc      = '0;
        req_check    = 1'b0;
        req_exp_pc   = '0;
        errors       = 0;
        checked      = 0;
        cycles       = 0;
        load_program();

        rows[0] = make_row(ACT_NONE, 32'h0, 1'b0, 1'b0, 12, 32'h0000_1048);
        rows[1] = make_row(ACT_NONE, 32'h0, 1'b0, 1'b1, 20, 32'h0000_1098);
        rows[2] = make_row(ACT_TRAIN, 32'h0000_1040, 1'b1, 1'b0, 0, 32'h0);
        rows[3] = make_row(ACT_TRAIN, 32'h0000_1040, 1'b1, 1'b0, 0, 32'h0);
        rows[4] = make_row(ACT_FLUSH, 32'h0000_1030, 1'b0, 1'b0, 8, 32'h0000_1038);
        rows[5] = make_row(ACT_FLUSH, 32'h0000_1100, 1'b0, 1'b1, 16, 32'h0000_113C);
        rows[6] = make_row(ACT_TRAIN, 32'h0000_1040, 1'b0, 1'b0, 0, 32'h0);
        rows[7] = make_row(ACT_TRAIN, 32'h0000_1040, 1'b0, 1'b0, 0, 32'h0);
        rows[8] = make_row(ACT_FLUSH, 32'h0000_1000, 1'b0, 1'b1, 24, 32'h0000_1078);

        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += 40 * rows[r].count;
        end

        repeat (5) @(negedge clk);
        reset = 1'b0;
        if (inst_valid) begin
            report_mismatch("inst_valid high right after reset");
        end
        req_check  = 1'b1;
        req_exp_pc = `FE_RESET_PC;

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
        end

        $display("Summary: %0d instructions checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/frontend_pkg.sv
design/pc_gen.sv
design/branch_predictor.sv
design/fetch_buffer.sv
design/frontend_top.sv
testbench/frontend_chk.sv
testbench/frontend_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module frontend_tb -f src.f -o frontend_sim

./obj_dir/frontend_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
